// ==== list.f ====
rtl/tetris_pkg.sv
rtl/playfield.sv
rtl/lines_manager.sv
rtl/garbage_meter.sv
rtl/lines_top.sv
tests/lines_tb.sv

// ==== Makefile ====
SOURCES = rtl/tetris_pkg.sv rtl/playfield.sv rtl/lines_manager.sv \
          rtl/garbage_meter.sv rtl/lines_top.sv tests/lines_tb.sv

.PHONY: all run clean

all: run

obj_dir/Vlines_tb: list.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module lines_tb -f list.f

run: obj_dir/Vlines_tb
	./obj_dir/Vlines_tb | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/lines_tb.sv ====
// directed testbench for lines_top, checks scoring, row removal and garbage against a model.
module lines_tb
    import tetris_pkg::*;
();

    logic                     clk;
    logic                     rst_l;
    logic                     game_start;
    logic                     lock;
    lock_t                    lock_info;
    logic                     garbage_in;
    logic [GARBAGE_WIDTH-1:0] garbage_count;
    board_t                   board;
    logic [COUNT_WIDTH-1:0]   lines_cleared;
    logic [COUNT_WIDTH-1:0]   lines_sent;
    logic [COMBO_WIDTH-1:0]   combo_count;
    logic [GARBAGE_WIDTH-1:0] garbage_pending;

    // expected state kept by the model.
    board_t exp_board;
    int     exp_cleared;
    int     exp_sent;
    int     exp_combo;
    int     exp_pending;
    bit     prev_clear;

    int     errors;
    int     test_errors;
    int     tests_run;
    int     cycles;
    string  test_name;
    integer seed;

    lines_top lines_top_inst (
        .clk             (clk),
        .rst_l           (rst_l),
        .game_start      (game_start),
        .lock            (lock),
        .lock_info       (lock_info),
        .garbage_in      (garbage_in),
        .garbage_count   (garbage_count),
        .board           (board),
        .lines_cleared   (lines_cleared),
        .lines_sent      (lines_sent),
        .combo_count     (combo_count),
        .garbage_pending (garbage_pending)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // run limit, well above the total test length.
    initial begin
        cycles = 0;
        while (cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within 2000 cycles");
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic int full_count(input board_t b);
        int n;
        n = 0;
        for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
            if (&b[r]) begin
                n++;
            end
        end
        return n;
    endfunction

    // each surviving row falls by the number of full rows beneath it.
    function automatic board_t drop_rows(input board_t b);
        board_t res;
        int     below;
        res = '0;
        below = 0;
        for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
            if (&b[r]) begin
                below++;
            end else begin
                res[r - below] = b[r];
            end
        end
        return res;
    endfunction

    function automatic int base_send(input int n, input bit tspin);
        if (tspin) begin
            return 2 * (n + 1);
        end
        case (n)
            2:       return 1;
            3:       return 2;
            4:       return 4;
            default: return 0;
        endcase
    endfunction

    function automatic int combo_bonus(input int c);
        case (c) inside
            0:       return 0;
            [1:2]:   return 1;
            [3:4]:   return 2;
            [5:6]:   return 3;
            [7:9]:   return 4;
            default: return 5;
        endcase
    endfunction

    function automatic int garbage_rule(input int pending, input int add, input int sub);
        int sum;
        sum = pending + add - sub;
        if (sum < 0) begin
            return 0;
        end
        if (sum > GARBAGE_MAX) begin
            return GARBAGE_MAX;
        end
        return sum;
    endfunction

    // random row with at least one hole so it never counts as full.
    function automatic row_t random_row();
        row_t r;
        r = row_t'($random(seed));
        r[$unsigned($random(seed)) % PLAYFIELD_COLS] = 1'b0;
        return r;
    endfunction

    function automatic int stack_height(input board_t b);
        int h;
        h = 0;
        for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
            if (b[r] != '0) begin
                h = r + 1;
            end
        end
        return h;
    endfunction

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("FAILED %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
        errors++;
        test_errors++;
    endtask

    task automatic compare_outputs();
        if (board !== exp_board) begin
            $display("FAILED %s: board expected %h, actual %h", test_name, exp_board, board);
            errors++;
            test_errors++;
        end
        if (lines_cleared !== COUNT_WIDTH'(exp_cleared)) begin
            report_mismatch("lines_cleared", exp_cleared, int'(lines_cleared));
        end
        if (lines_sent !== COUNT_WIDTH'(exp_sent)) begin
            report_mismatch("lines_sent", exp_sent, int'(lines_sent));
        end
        if (combo_count !== COMBO_WIDTH'(exp_combo)) begin
            report_mismatch("combo_count", exp_combo, int'(combo_count));
        end
        if (garbage_pending !== GARBAGE_WIDTH'(exp_pending)) begin
            report_mismatch("garbage_pending", exp_pending, int'(garbage_pending));
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %s: passed", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, test_errors);
        end
    endtask

    task automatic start_game();
        @(posedge clk);
        #1;
        game_start = 1'b1;
        @(posedge clk);
        #1;
        game_start = 1'b0;
        exp_board = '0;
        exp_cleared = 0;
        exp_sent = 0;
        exp_combo = 0;
        exp_pending = 0;
        prev_clear = 1'b0;
        compare_outputs();
    endtask

    // gar below zero means no garbage pulse; otherwise it lands with the attack.
    task automatic lock_piece(input board_t cells, input bit tspin, input int gar);
        board_t merged;
        int     n;
        int     send;
        merged = exp_board | cells;
        n = full_count(merged);
        send = 0;
        if (n > 0) begin
            send = base_send(n, tspin) + combo_bonus(exp_combo);
            exp_cleared += n;
            exp_sent += send;
            if (prev_clear && exp_combo < 31) begin
                exp_combo++;
            end
            prev_clear = 1'b1;
        end else begin
            exp_combo = 0;
            prev_clear = 1'b0;
        end
        exp_board = drop_rows(merged);
        @(posedge clk);
        #1;
        lock = 1'b1;
        lock_info.cells = cells;
        lock_info.tspin = tspin;
        @(posedge clk);
        #1;
        lock = 1'b0;
        lock_info = '0;
        // board and totals have settled, attack is valid during this cycle.
        @(posedge clk);
        #1;
        compare_outputs();
        if (gar >= 0) begin
            garbage_in = 1'b1;
            garbage_count = GARBAGE_WIDTH'(gar);
        end
        @(posedge clk);
        #1;
        garbage_in = 1'b0;
        garbage_count = '0;
        exp_pending = garbage_rule(exp_pending, (gar >= 0) ? gar : 0, send);
        compare_outputs();
    endtask

    task automatic pulse_garbage(input int count);
        exp_pending = garbage_rule(exp_pending, count, 0);
        @(posedge clk);
        #1;
        garbage_in = 1'b1;
        garbage_count = GARBAGE_WIDTH'(count);
        @(posedge clk);
        #1;
        garbage_in = 1'b0;
        garbage_count = '0;
        compare_outputs();
    endtask

    // near-full rows on top of the stack, random rows above them, then the filling lock.
    task automatic clear_rows(input int n, input int extra, input bit tspin, input int gar);
        board_t setup;
        board_t fill;
        int     top;
        int     gap;
        top = stack_height(exp_board);
        setup = '0;
        fill = '0;
        for (int i = 0; i < n; i++) begin
            gap = $unsigned($random(seed)) % PLAYFIELD_COLS;
            setup[top + i] = '1;
            setup[top + i][gap] = 1'b0;
            fill[top + i][gap] = 1'b1;
        end
        for (int i = 0; i < extra; i++) begin
            setup[top + n + i] = random_row();
        end
        lock_piece(setup, 1'b0, -1);
        lock_piece(fill, tspin, gar);
    endtask

    task automatic zero_after_reset();
        board_t cells;
        begin_test("reset_values");
        compare_outputs();
        // a clear straight after reset starts a new chain.
        cells = '0;
        cells[0] = '1;
        cells[1] = random_row();
        cells[2] = random_row();
        lock_piece(cells, 1'b1, -1);
        cells = '0;
        cells[0] = ~exp_board[0];
        lock_piece(cells, 1'b0, -1);
        pulse_garbage(5);
        start_game();
        // the chain is broken again after a new game.
        cells = '0;
        cells[0] = '1;
        lock_piece(cells, 1'b0, -1);
        finish_test();
    endtask

    task automatic clear_one_to_four();
        int single_send[4] = '{0, 1, 2, 4};
        int sent_before;
        begin_test("line_clears");
        start_game();
        for (int n = 1; n <= 4; n++) begin
            sent_before = int'(lines_sent);
            clear_rows(n, 2, 1'b0, -1);
            if (int'(lines_sent) - sent_before != single_send[n-1]) begin
                report_mismatch("send step", single_send[n-1], int'(lines_sent) - sent_before);
            end
        end
        finish_test();
    endtask

    task automatic tspin_sends();
        begin_test("tspin_clears");
        start_game();
        for (int n = 1; n <= 3; n++) begin
            clear_rows(n, 1, 1'b1, -1);
        end
        finish_test();
    endtask

    task automatic combo_chain();
        board_t setup;
        board_t fill;
        begin_test("combo_chain");
        start_game();
        setup = '0;
        for (int r = 0; r < 12; r++) begin
            setup[r] = '1;
            setup[r][r % PLAYFIELD_COLS] = 1'b0;
        end
        setup[12] = random_row();
        setup[13] = random_row();
        lock_piece(setup, 1'b0, -1);
        for (int i = 0; i < 12; i++) begin
            fill = '0;
            for (int c = 0; c < PLAYFIELD_COLS; c++) begin
                if (!exp_board[0][c]) begin
                    fill[0][c] = 1'b1;
                end
            end
            lock_piece(fill, 1'b0, -1);
            if (combo_count !== COMBO_WIDTH'(i)) begin
                report_mismatch("combo step", i, int'(combo_count));
            end
        end
        // a lone cell at the top ends the chain.
        fill = '0;
        fill[PLAYFIELD_ROWS-1][0] = 1'b1;
        lock_piece(fill, 1'b0, -1);
        finish_test();
    endtask

    task automatic row_shift();
        begin_test("row_shift");
        start_game();
        clear_rows(3, 5, 1'b0, -1);
        clear_rows(2, 4, 1'b0, -1);
        finish_test();
    endtask

    task automatic garbage_cancel();
        begin_test("garbage_meter");
        start_game();
        pulse_garbage(7);
        pulse_garbage(9);
        pulse_garbage(10);
        pulse_garbage(31);
        clear_rows(4, 0, 1'b0, 3);
        clear_rows(3, 0, 1'b1, -1);
        clear_rows(3, 0, 1'b1, 2);
        // cancel goes below zero with a pulse in the same cycle.
        clear_rows(3, 0, 1'b1, 1);
        finish_test();
    endtask

    initial begin
        seed = 32'hc9e1;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        test_name = "";
        rst_l = 1'b0;
        game_start = 1'b0;
        lock = 1'b0;
        lock_info = '0;
        garbage_in = 1'b0;
        garbage_count = '0;
        exp_board = '0;
        exp_cleared = 0;
        exp_sent = 0;
        exp_combo = 0;
        exp_pending = 0;
        prev_clear = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_l = 1'b1;
        zero_after_reset();
        clear_one_to_four();
        tspin_sends();
        combo_chain();
        row_shift();
        garbage_cancel();
        $display("summary: %0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== rtl/lines_top.sv ====
// line-clear scoring path, joins the playfield, scoring and garbage meter for one player.
module lines_top
    import tetris_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_l,
    input  logic                     game_start,
    input  logic                     lock,
    input  lock_t                    lock_info,
    input  logic                     garbage_in,
    input  logic [GARBAGE_WIDTH-1:0] garbage_count,
    output board_t                   board,
    output logic [COUNT_WIDTH-1:0]   lines_cleared,
    output logic [COUNT_WIDTH-1:0]   lines_sent,
    output logic [COMBO_WIDTH-1:0]   combo_count,
    output logic [GARBAGE_WIDTH-1:0] garbage_pending
);

    logic [PLAYFIELD_ROWS-1:0] full_rows;
    logic                      check;
    logic                      check_tspin;
    attack_t                   attack;

    playfield playfield_inst (
        .clk         (clk),
        .rst_l       (rst_l),
        .game_start  (game_start),
        .lock        (lock),
        .lock_info   (lock_info),
        .board       (board),
        .full_rows   (full_rows),
        .check       (check),
        .check_tspin (check_tspin)
    );

    lines_manager lines_manager_inst (
        .clk           (clk),
        .rst_l         (rst_l),
        .game_start    (game_start),
        .check         (check),
        .check_tspin   (check_tspin),
        .full_rows     (full_rows),
        .lines_cleared (lines_cleared),
        .lines_sent    (lines_sent),
        .combo_count   (combo_count),
        .attack        (attack)
    );

    garbage_meter garbage_meter_inst (
        .clk             (clk),
        .rst_l           (rst_l),
        .game_start      (game_start),
        .garbage_in      (garbage_in),
        .garbage_count   (garbage_count),
        .attack          (attack),
        .garbage_pending (garbage_pending)
    );

endmodule

// ==== rtl/garbage_meter.sv ====
// pending incoming garbage, cancelled by outgoing attack and capped for the loading bar.
module garbage_meter
    import tetris_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_l,
    input  logic                     game_start,
    input  logic                     garbage_in,
    input  logic [GARBAGE_WIDTH-1:0] garbage_count,
    input  attack_t                  attack,
    output logic [GARBAGE_WIDTH-1:0] garbage_pending
);

    // wide enough for the largest attack subtracted from an empty meter.
    logic signed [COUNT_WIDTH+1:0] next_sum;
    logic        [GARBAGE_WIDTH-1:0] next_pending;

    // adds and cancels may land in the same cycle.
    always_comb begin
        next_sum = (COUNT_WIDTH+2)'(garbage_pending);
        if (garbage_in) begin
            next_sum = next_sum + (COUNT_WIDTH+2)'(garbage_count);
        end
        if (attack.valid) begin
            next_sum = next_sum - (COUNT_WIDTH+2)'(attack.lines);
        end
    end

    // floor at zero, cap at the meter size.
    always_comb begin
        if (next_sum < 0) begin
            next_pending = '0;
        end else if (next_sum > GARBAGE_MAX) begin
            next_pending = GARBAGE_WIDTH'(GARBAGE_MAX);
        end else begin
            next_pending = GARBAGE_WIDTH'(next_sum);
        end
    end

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            garbage_pending <= '0;
        end else if (game_start) begin
            garbage_pending <= '0;
        end else begin
            garbage_pending <= next_pending;
        end
    end

    // a cancel without incoming garbage never raises the meter.
    assert property (@(posedge clk) disable iff (!rst_l)
        (attack.valid && !garbage_in) |=> garbage_pending <= $past(garbage_pending))
    else $error("attack raised garbage pending");

endmodule

// ==== rtl/lines_manager.sv ====
// per-lock scoring, keeps lines cleared, lines sent and the combo count and emits the attack.
module lines_manager
    import tetris_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_l,
    input  logic                      game_start,
    input  logic                      check,
    input  logic                      check_tspin,
    input  logic [PLAYFIELD_ROWS-1:0] full_rows,
    output logic [COUNT_WIDTH-1:0]    lines_cleared,
    output logic [COUNT_WIDTH-1:0]    lines_sent,
    output logic [COMBO_WIDTH-1:0]    combo_count,
    output attack_t                   attack
);

    typedef enum logic {
        COMBO_BREAK,
        COMBO_CHAIN
    } combo_state_t;

    combo_state_t combo_state;

    logic [COUNT_WIDTH-1:0] rows_cleared;
    logic [COUNT_WIDTH-1:0] base_send;
    logic [COUNT_WIDTH-1:0] combo_bonus;
    logic [COUNT_WIDTH-1:0] lines_to_send;
    logic                   clearing;

    function automatic logic [COUNT_WIDTH-1:0] count_rows(input logic [PLAYFIELD_ROWS-1:0] rows);
        logic [COUNT_WIDTH-1:0] total;
        total = '0;
        for (int i = 0; i < PLAYFIELD_ROWS; i++) begin
            total = total + COUNT_WIDTH'(rows[i]);
        end
        return total;
    endfunction

    assign rows_cleared = count_rows(full_rows);
    assign clearing     = (rows_cleared != '0);

    // base send table, t-spins send double of rows plus one.
    always_comb begin
        if (check_tspin) begin
            base_send = (rows_cleared + COUNT_WIDTH'(1)) << 1;
        end else begin
            case (rows_cleared)
                COUNT_WIDTH'(2): base_send = COUNT_WIDTH'(1);
                COUNT_WIDTH'(3): base_send = COUNT_WIDTH'(2);
                COUNT_WIDTH'(4): base_send = COUNT_WIDTH'(4);
                default:         base_send = '0;
            endcase
        end
    end

    // bonus from the combo count held before this lock.
    always_comb begin
        if (combo_count == '0) begin
            combo_bonus = '0;
        end else if (combo_count < 3) begin
            combo_bonus = COUNT_WIDTH'(1);
        end else if (combo_count < 5) begin
            combo_bonus = COUNT_WIDTH'(2);
        end else if (combo_count < 7) begin
            combo_bonus = COUNT_WIDTH'(3);
        end else if (combo_count < 10) begin
            combo_bonus = COUNT_WIDTH'(4);
        end else begin
            combo_bonus = COUNT_WIDTH'(5);
        end
    end

    assign lines_to_send = base_send + combo_bonus;

    // totals, combo chain and the attack pulse all move on check.
    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            lines_cleared <= '0;
            lines_sent    <= '0;
            combo_count   <= '0;
            combo_state   <= COMBO_BREAK;
            attack        <= '0;
        end else if (game_start) begin
            lines_cleared <= '0;
            lines_sent    <= '0;
            combo_count   <= '0;
            combo_state   <= COMBO_BREAK;
            attack        <= '0;
        end else begin
            attack.valid <= check && clearing;
            attack.lines <= lines_to_send;
            if (check && clearing) begin
                lines_cleared <= lines_cleared + rows_cleared;
                lines_sent    <= lines_sent + lines_to_send;
                combo_state   <= COMBO_CHAIN;
                // only a second clear in a row extends the chain.
                if (combo_state == COMBO_CHAIN && combo_count != '1) begin
                    combo_count <= combo_count + 1'b1;
                end
            end else if (check) begin
                combo_count <= '0;
                combo_state <= COMBO_BREAK;
            end
        end
    end

    // attack stays a one-cycle pulse since checks never come back to back.
    assert property (@(posedge clk) disable iff (!rst_l)
        attack.valid |=> !attack.valid)
    else $error("attack held for more than one cycle");

endmodule

// ==== rtl/playfield.sv ====
// settled board storage, merges locked pieces and removes full rows one cycle later.
module playfield
    import tetris_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_l,
    input  logic                      game_start,
    input  logic                      lock,
    input  lock_t                     lock_info,
    output board_t                    board,
    output logic [PLAYFIELD_ROWS-1:0] full_rows,
    output logic                      check,
    output logic                      check_tspin
);

    board_t compacted;

    // a row is full when every column is occupied.
    always_comb begin
        for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
            full_rows[r] = &board[r];
        end
    end

    // drop surviving rows down, empty rows fill in from the top.
    always_comb begin
        int dst;
        compacted = '0;
        dst = 0;
        for (int src = 0; src < PLAYFIELD_ROWS; src++) begin
            if (!full_rows[src]) begin
                compacted[dst] = board[src];
                dst = dst + 1;
            end
        end
    end

    // board update, merge on lock and compaction on check.
    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            board <= '0;
        end else if (game_start) begin
            board <= '0;
        end else if (lock) begin
            board <= board | lock_info.cells;
        end else if (check) begin
            board <= compacted;
        end
    end

    // check follows the lock by one cycle, once the merged board is visible.
    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            check       <= 1'b0;
            check_tspin <= 1'b0;
        end else begin
            check       <= lock && !game_start;
            check_tspin <= lock && !game_start && lock_info.tspin;
        end
    end

    // a locking piece only lands on empty cells.
    assert property (@(posedge clk) disable iff (!rst_l)
        (lock && !game_start) |-> ((board & lock_info.cells) == '0))
    else $error("piece locked over occupied cells");

    // locks are spaced so the compaction finishes before the next merge.
    assert property (@(posedge clk) disable iff (!rst_l)
        check |-> !lock ##1 !lock)
    else $error("lock arrived during row compaction");

endmodule

// ==== rtl/tetris_pkg.sv ====
// shared board dimensions, score limits and packed types, imported by the line-clear path.
package tetris_pkg;

    // board geometry.
    localparam int PLAYFIELD_ROWS = 20;
    localparam int PLAYFIELD_COLS = 10;

    // totals and per-lock attack amounts.
    localparam int COUNT_WIDTH = 10;

    // longest combo in practice is well under 31.
    localparam int COMBO_WIDTH = 5;

    // incoming garbage limits.
    localparam int GARBAGE_MAX = 20;
    localparam int GARBAGE_WIDTH = 5;

    // one row, one bit per column.
    typedef logic [PLAYFIELD_COLS-1:0] row_t;

    // whole board, row 0 is the bottom row.
    typedef row_t [PLAYFIELD_ROWS-1:0] board_t;

    // piece lock, cells holds only the locking piece.
    typedef struct packed {
        board_t cells;
        logic   tspin;
    } lock_t;

    // attack produced by one clearing lock.
    typedef struct packed {
        logic                   valid;
        logic [COUNT_WIDTH-1:0] lines;
    } attack_t;

endpackage
